// ==== build.f ====
source/vec_pkg.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_mask_unit.sv
source/vec_unit.sv
bench/vec_unit_assert.sv
bench/vec_unit_tb.sv

// ==== bench/vec_unit_tb.sv ====
/*
  Directed testbench for the vector coprocessor.
  Inputs change on the falling clock edge, outputs are sampled there too.
  Register contents are undefined after reset, so the first test fills
  every register before anything reads it.
*/
`timescale 1ns/1ps

module vec_unit_tb;
  import vec_pkg::*;

  localparam int ReqTimeout  = 200;
  localparam int RespTimeout = 200;
  localparam int IdleTimeout = 500;

  logic    clk_i;
  logic    rst_n_i;
  logic    req_valid_i;
  logic    req_ready_o;
  vec_op_e req_op_i;
  vreg_t   req_vd_i;
  vreg_t   req_vs1_i;
  vreg_t   req_vs2_i;
  elem_t   req_scalar_i;
  vl_t     req_vl_i;
  logic    resp_valid_o;
  elem_t   resp_data_o;
  logic    resp_ready_i;
  logic    idle_o;

  // Reference register file, element i of register r at model[r][i]
  elem_t model [NrVRegs][VlMax];

  int n_checks;
  int n_elem_err;
  int n_count_err;
  int n_flag_err;
  int n_timeouts;

  vec_unit vec_unit_i (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_op_i     (req_op_i    ),
    .req_vd_i     (req_vd_i    ),
    .req_vs1_i    (req_vs1_i   ),
    .req_vs2_i    (req_vs2_i   ),
    .req_scalar_i (req_scalar_i),
    .req_vl_i     (req_vl_i    ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o ),
    .resp_ready_i (resp_ready_i),
    .idle_o       (idle_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Run control and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic finish_run();
    $display("checks %0d, element errors %0d, count errors %0d, flag errors %0d, timeouts %0d",
             n_checks, n_elem_err, n_count_err, n_flag_err, n_timeouts);
    if (n_elem_err + n_count_err + n_flag_err + n_timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    n_timeouts++;
    $display("timeout: %s", what);
    finish_run();
  endtask

  task automatic check_elem(input string sig, input elem_t got, input elem_t exp);
    n_checks++;
    if (got !== exp) begin
      n_elem_err++;
      $display("error: %s got 0x%08h expected 0x%08h", sig, got, exp);
    end
  endtask

  task automatic check_count(input string sig, input elem_t got, input elem_t exp);
    n_checks++;
    if (got !== exp) begin
      n_count_err++;
      $display("error: %s got 0x%08h expected 0x%08h", sig, got, exp);
    end
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_flag_err++;
      $display("error: %s got 0x%0h expected 0x%0h", sig, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int clamp_vl(input vl_t vl);
    return (vl > VlMax) ? VlMax : int'(vl);
  endfunction

  task automatic update_model(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                              input vreg_t vs2, input elem_t scalar, input vl_t vl);
    int n;
    n = clamp_vl(vl);
    // Elements at or above vl keep their value
    for (int i = 0; i < n; i++) begin
      case (op)
        VADD_VV: model[vd][i] = model[vs2][i] + model[vs1][i];
        VSUB_VV: model[vd][i] = model[vs2][i] - model[vs1][i];
        VAND_VV: model[vd][i] = model[vs2][i] & model[vs1][i];
        VOR_VV:  model[vd][i] = model[vs2][i] | model[vs1][i];
        VXOR_VV: model[vd][i] = model[vs2][i] ^ model[vs1][i];
        VADD_VX: model[vd][i] = model[vs2][i] + scalar;
        VMV_VX:  model[vd][i] = scalar;
        default: ;
      endcase
    end
  endtask

  function automatic elem_t expect_scalar(input vec_op_e op, input vreg_t vs2,
                                          input elem_t scalar, input vl_t vl);
    int    n;
    int    idx;
    elem_t acc;
    n   = clamp_vl(vl);
    acc = '0;
    if (op == VCPOP_M) begin
      for (int i = 0; i < n; i++) begin
        acc = acc + elem_t'(model[vs2][i][0]);
      end
    end else begin
      idx = int'(scalar % VlMax);
      if (idx < n) begin
        acc = model[vs2][idx];
      end
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Port tasks
  //////////////////////////////////////////////////////////////////////

  task automatic send_req(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                          input vreg_t vs2, input elem_t scalar, input vl_t vl);
    int waits;
    waits = 0;
    @(negedge clk_i);
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_vd_i     = vd;
    req_vs1_i    = vs1;
    req_vs2_i    = vs2;
    req_scalar_i = scalar;
    req_vl_i     = vl;
    while (!req_ready_o && waits < ReqTimeout) begin
      @(negedge clk_i);
      waits++;
    end
    if (!req_ready_o) begin
      report_timeout("req_ready_o stayed low and the request was never accepted");
    end else begin
      // Transfer happens at the rising edge in between
      @(negedge clk_i);
      req_valid_i = 1'b0;
    end
  endtask

  task automatic get_resp(input int stall, output elem_t data);
    int    waits;
    elem_t first;
    waits = 0;
    while (!resp_valid_o && waits < RespTimeout) begin
      @(negedge clk_i);
      waits++;
    end
    if (!resp_valid_o) begin
      report_timeout("resp_valid_o never rose for a scalar operation");
    end else begin
      first = resp_data_o;
      // Hold off the response and watch that it stays put
      for (int s = 0; s < stall; s++) begin
        @(negedge clk_i);
        check_flag("resp_valid_o", resp_valid_o, 1'b1);
        check_elem("resp_data_o stalled", resp_data_o, first);
      end
      resp_ready_i = 1'b1;
      data         = resp_data_o;
      @(negedge clk_i);
      resp_ready_i = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int waits;
    waits = 0;
    while (!idle_o && waits < IdleTimeout) begin
      @(negedge clk_i);
      waits++;
    end
    if (!idle_o) begin
      report_timeout("idle_o did not return high");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Operation helpers
  //////////////////////////////////////////////////////////////////////

  task automatic run_vec(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                         input vreg_t vs2, input elem_t scalar, input vl_t vl);
    update_model(op, vd, vs1, vs2, scalar, vl);
    send_req(op, vd, vs1, vs2, scalar, vl);
  endtask

  task automatic run_scalar(input vec_op_e op, input vreg_t vs2, input elem_t scalar,
                            input vl_t vl, input int stall);
    elem_t exp;
    elem_t got;
    exp = expect_scalar(op, vs2, scalar, vl);
    send_req(op, vs2, vs2, vs2, scalar, vl);
    get_resp(stall, got);
    if (op == VCPOP_M) begin
      check_count($sformatf("resp_data_o cpop v%0d vl %0d", vs2, vl), got, exp);
    end else begin
      check_elem($sformatf("resp_data_o v%0d idx %0d vl %0d", vs2, scalar, vl), got, exp);
    end
  endtask

  // Distinct values per element from shrinking broadcasts
  task automatic fill_random(input vreg_t r);
    for (int k = VlMax; k >= 1; k--) begin
      run_vec(VMV_VX, r, r, r, elem_t'($urandom), vl_t'(k));
    end
  endtask

  task automatic check_reg(input vreg_t r);
    for (int i = 0; i < VlMax; i++) begin
      run_scalar(VEXT_XV, r, elem_t'(i), vl_t'(VlMax), 0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic broadcast_and_extract();
    for (int r = 0; r < NrVRegs; r++) begin
      run_vec(VMV_VX, vreg_t'(r), '0, '0, elem_t'($urandom), vl_t'(VlMax));
    end
    wait_idle();
    for (int r = 0; r < NrVRegs; r++) begin
      check_reg(vreg_t'(r));
    end
  endtask

  task automatic arith_and_logic();
    fill_random(3'd1);
    fill_random(3'd2);
    run_vec(VADD_VV, 3'd3, 3'd1, 3'd2, '0, vl_t'(VlMax));
    run_vec(VSUB_VV, 3'd4, 3'd1, 3'd2, '0, vl_t'(VlMax));
    run_vec(VAND_VV, 3'd5, 3'd1, 3'd2, '0, vl_t'(VlMax));
    run_vec(VOR_VV,  3'd6, 3'd1, 3'd2, '0, vl_t'(VlMax));
    run_vec(VXOR_VV, 3'd7, 3'd1, 3'd2, '0, vl_t'(VlMax));
    run_vec(VADD_VX, 3'd0, 3'd0, 3'd1, elem_t'($urandom), vl_t'(VlMax));
    wait_idle();
    check_reg(3'd0);
    for (int r = 3; r < NrVRegs; r++) begin
      check_reg(vreg_t'(r));
    end
  endtask

  task automatic tail_and_clamp();
    fill_random(3'd2);
    fill_random(3'd3);
    fill_random(3'd4);
    fill_random(3'd5);
    run_vec(VADD_VX, 3'd3, 3'd3, 3'd2, elem_t'($urandom), vl_t'(5));
    run_vec(VMV_VX,  3'd4, 3'd4, 3'd4, elem_t'($urandom), vl_t'(0));
    run_vec(VXOR_VV, 3'd5, 3'd2, 3'd5, '0, vl_t'(20));
    wait_idle();
    check_reg(3'd3);
    check_reg(3'd4);
    check_reg(3'd5);
    // Index past vl, empty vl, wrapped index and clamped vl
    run_scalar(VEXT_XV, 3'd2, elem_t'(9), vl_t'(5), 0);
    run_scalar(VEXT_XV, 3'd2, elem_t'(0), vl_t'(0), 0);
    run_scalar(VEXT_XV, 3'd2, elem_t'(VlMax + 3), vl_t'(VlMax), 0);
    run_scalar(VEXT_XV, 3'd2, elem_t'(15), vl_t'(20), 0);
  endtask

  task automatic popcount_random_vl();
    repeat (8) begin
      run_scalar(VCPOP_M, vreg_t'($urandom_range(0, NrVRegs - 1)), '0,
                 vl_t'($urandom_range(0, 20)), 0);
    end
    run_scalar(VCPOP_M, 3'd2, '0, vl_t'(0), 0);
  endtask

  task automatic dependent_chain();
    run_vec(VADD_VV, 3'd3, 3'd1, 3'd2, '0, vl_t'(VlMax));
    run_vec(VXOR_VV, 3'd4, 3'd1, 3'd3, '0, vl_t'(VlMax));
    run_vec(VSUB_VV, 3'd5, 3'd3, 3'd4, '0, vl_t'(VlMax));
    run_vec(VADD_VX, 3'd6, 3'd6, 3'd5, elem_t'($urandom), vl_t'(VlMax));
    run_vec(VAND_VV, 3'd7, 3'd2, 3'd6, '0, vl_t'(VlMax));
    run_vec(VOR_VV,  3'd1, 3'd5, 3'd7, '0, vl_t'(11));
    // Scalar read right behind the last write
    run_scalar(VEXT_XV, 3'd1, elem_t'($urandom_range(0, VlMax - 1)), vl_t'(VlMax), 0);
    wait_idle();
    check_reg(3'd1);
    for (int r = 3; r < NrVRegs; r++) begin
      check_reg(vreg_t'(r));
    end
  endtask

  task automatic response_backpressure();
    elem_t   exp_q [$];
    vec_op_e kind_q [$];
    fork
      begin
        vec_op_e op;
        vreg_t   vs2;
        elem_t   scalar;
        vl_t     vl;
        for (int n = 0; n < 10; n++) begin
          op     = ($urandom_range(0, 1) == 0) ? VCPOP_M : VEXT_XV;
          vs2    = vreg_t'($urandom_range(0, NrVRegs - 1));
          scalar = elem_t'($urandom_range(0, 40));
          vl     = vl_t'($urandom_range(0, 20));
          exp_q.push_back(expect_scalar(op, vs2, scalar, vl));
          kind_q.push_back(op);
          send_req(op, vs2, vs2, vs2, scalar, vl);
        end
      end
      begin
        elem_t   got;
        elem_t   exp;
        vec_op_e kind;
        for (int n = 0; n < 10; n++) begin
          get_resp($urandom_range(0, 6), got);
          if (exp_q.size() == 0) begin
            n_flag_err++;
            $display("response arrived with no scalar request outstanding");
          end else begin
            exp  = exp_q.pop_front();
            kind = kind_q.pop_front();
            if (kind == VCPOP_M) begin
              check_count($sformatf("resp_data_o cpop response %0d", n), got, exp);
            end else begin
              check_elem($sformatf("resp_data_o extract response %0d", n), got, exp);
            end
          end
        end
      end
    join
    wait_idle();
    check_flag("resp_valid_o after last response", resp_valid_o, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    n_checks     = 0;
    n_elem_err   = 0;
    n_count_err  = 0;
    n_flag_err   = 0;
    n_timeouts   = 0;
    void'($urandom(68711));
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = VADD_VV;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_scalar_i = '0;
    req_vl_i     = '0;
    resp_ready_i = 1'b0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VlMax; i++) begin
        model[r][i] = '0;
      end
    end

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    check_flag("resp_valid_o", resp_valid_o, 1'b0);
    check_flag("idle_o", idle_o, 1'b1);

    broadcast_and_extract();
    arith_and_logic();
    tail_and_clamp();
    popcount_random_vl();
    dependent_chain();
    response_backpressure();

    finish_run();
  end

endmodule : vec_unit_tb

// ==== bench/vec_unit_assert.sv ====
/*
  Handshake properties of the vector coprocessor top level.
  Bound into every vec_unit instance.
*/
`timescale 1ns/1ps

module vec_unit_assert import vec_pkg::*; (
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  req_valid_i,
  input logic  req_ready_o,
  input logic  resp_valid_o,
  input elem_t resp_data_o,
  input logic  resp_ready_i,
  input logic  idle_o
);

  // Stalled response keeps valid and data
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
    else $error("response changed while stalled");

  reset_outputs: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> req_ready_o && !resp_valid_o && idle_o)
    else $error("outputs not inactive after reset");

  // A taken request is held for at least one cycle
  req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_o |=> !req_ready_o)
    else $error("req_ready_o high while a request is held");

endmodule : vec_unit_assert

bind vec_unit vec_unit_assert vec_unit_assert_i (
  .clk_i        (clk_i       ),
  .rst_n_i      (rst_n_i     ),
  .req_valid_i  (req_valid_i ),
  .req_ready_o  (req_ready_o ),
  .resp_valid_o (resp_valid_o),
  .resp_data_o  (resp_data_o ),
  .resp_ready_i (resp_ready_i),
  .idle_o       (idle_o      )
);

// ==== source/vec_unit.sv ====
/*
  Vector coprocessor top: dispatcher, sequencer, lanes and mask unit.
  Only VCPOP_M and VEXT_XV answer on the response port, in request order.
*/
`timescale 1ns/1ps

module vec_unit import vec_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Request port
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  vec_op_e req_op_i,
  input  vreg_t   req_vd_i,
  input  vreg_t   req_vs1_i,
  input  vreg_t   req_vs2_i,
  input  elem_t   req_scalar_i,
  input  vl_t     req_vl_i,
  // Response port
  output logic    resp_valid_o,
  output elem_t   resp_data_o,
  input  logic    resp_ready_i,
  output logic    idle_o
);

  //////////////////////////////////////////////////////////////////////
  // Dispatcher
  //////////////////////////////////////////////////////////////////////

  logic    issue_valid;
  logic    issue_ready;
  vec_op_e issue_op;
  vreg_t   issue_vd;
  vreg_t   issue_vs1;
  vreg_t   issue_vs2;
  elem_t   issue_scalar;
  vl_t     issue_vl;

  vec_dispatcher i_dispatcher (
    .clk_i          (clk_i       ),
    .rst_n_i        (rst_n_i     ),
    .req_valid_i    (req_valid_i ),
    .req_ready_o    (req_ready_o ),
    .req_op_i       (req_op_i    ),
    .req_vd_i       (req_vd_i    ),
    .req_vs1_i      (req_vs1_i   ),
    .req_vs2_i      (req_vs2_i   ),
    .req_scalar_i   (req_scalar_i),
    .req_vl_i       (req_vl_i    ),
    .issue_valid_o  (issue_valid ),
    .issue_ready_i  (issue_ready ),
    .issue_op_o     (issue_op    ),
    .issue_vd_o     (issue_vd    ),
    .issue_vs1_o    (issue_vs1   ),
    .issue_vs2_o    (issue_vs2   ),
    .issue_scalar_o (issue_scalar),
    .issue_vl_o     (issue_vl    ),
    .resp_pending_i (resp_valid_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  logic               rd_valid;
  slot_t              rd_slot;
  vreg_t              rd_vs1;
  vreg_t              rd_vs2;
  logic               wb_valid;
  slot_t              wb_slot;
  vreg_t              wb_vd;
  vec_op_e            wb_op;
  elem_t              wb_scalar;
  logic [NrLanes-1:0] wb_active;
  logic               red_valid;
  logic               red_first;
  logic               red_last;
  vec_op_e            red_op;
  slot_t              red_slot;
  logic [NrLanes-1:0] red_active;
  elem_t              red_index;
  logic               red_ready;
  logic               seq_busy;

  vec_sequencer i_sequencer (
    .clk_i          (clk_i       ),
    .rst_n_i        (rst_n_i     ),
    .issue_valid_i  (issue_valid ),
    .issue_ready_o  (issue_ready ),
    .issue_op_i     (issue_op    ),
    .issue_vd_i     (issue_vd    ),
    .issue_vs1_i    (issue_vs1   ),
    .issue_vs2_i    (issue_vs2   ),
    .issue_scalar_i (issue_scalar),
    .issue_vl_i     (issue_vl    ),
    .rd_valid_o     (rd_valid    ),
    .rd_slot_o      (rd_slot     ),
    .rd_vs1_o       (rd_vs1      ),
    .rd_vs2_o       (rd_vs2      ),
    .wb_valid_o     (wb_valid    ),
    .wb_slot_o      (wb_slot     ),
    .wb_vd_o        (wb_vd       ),
    .wb_op_o        (wb_op       ),
    .wb_scalar_o    (wb_scalar   ),
    .wb_active_o    (wb_active   ),
    .red_valid_o    (red_valid   ),
    .red_first_o    (red_first   ),
    .red_last_o     (red_last    ),
    .red_op_o       (red_op      ),
    .red_slot_o     (red_slot    ),
    .red_active_o   (red_active  ),
    .red_index_o    (red_index   ),
    .red_ready_i    (red_ready   ),
    .busy_o         (seq_busy    )
  );

  //////////////////////////////////////////////////////////////////////
  // Lanes and mask unit
  //////////////////////////////////////////////////////////////////////

  elem_t lane_vs2 [NrLanes];

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i       (clk_i             ),
      .rst_n_i     (rst_n_i           ),
      .lane_id_i   (LaneIdWidth'(l)   ),
      .rd_valid_i  (rd_valid          ),
      .rd_slot_i   (rd_slot           ),
      .rd_vs1_i    (rd_vs1            ),
      .rd_vs2_i    (rd_vs2            ),
      .wb_valid_i  (wb_valid          ),
      .wb_slot_i   (wb_slot           ),
      .wb_vd_i     (wb_vd             ),
      .wb_op_i     (wb_op             ),
      .wb_scalar_i (wb_scalar         ),
      .wb_active_i (wb_active         ),
      .lane_vs2_o  (lane_vs2[l]       )
    );
  end : gen_lanes

  vec_mask_unit i_mask_unit (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .red_valid_i  (red_valid   ),
    .red_first_i  (red_first   ),
    .red_last_i   (red_last    ),
    .red_op_i     (red_op      ),
    .red_slot_i   (red_slot    ),
    .red_active_i (red_active  ),
    .red_index_i  (red_index   ),
    .red_ready_o  (red_ready   ),
    .lane_vs2_i   (lane_vs2    ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o ),
    .resp_ready_i (resp_ready_i)
  );

  // Nothing held, in flight or waiting at the response port
  assign idle_o = ~seq_busy & req_ready_o & ~resp_valid_o;

endmodule : vec_unit

// ==== source/vec_mask_unit.sv ====
/*
  Reduces lane elements to one scalar and holds it on the response port.
  Only one reduction is handled at a time: red_ready_o stays low
  until the pending response has been taken.
*/
`timescale 1ns/1ps

module vec_mask_unit import vec_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // From the sequencer
  input  logic               red_valid_i,
  input  logic               red_first_i,
  input  logic               red_last_i,
  input  vec_op_e            red_op_i,
  input  slot_t              red_slot_i,
  input  logic [NrLanes-1:0] red_active_i,
  input  elem_t              red_index_i,
  output logic               red_ready_o,
  // vs2 elements of the current slot
  input  elem_t              lane_vs2_i [NrLanes],
  // Scalar response
  output logic               resp_valid_o,
  output elem_t              resp_data_o,
  input  logic               resp_ready_i
);

  logic [ElemIdxWidth-1:0] ext_idx;
  logic [LaneIdWidth-1:0]  ext_lane;
  slot_t                   ext_slot;
  elem_t                   acc_q;
  elem_t                   acc_d;

  // Extract index wraps at VlMax
  assign ext_idx  = red_index_i[ElemIdxWidth-1:0];
  assign ext_lane = ext_idx[LaneIdWidth-1:0];
  assign ext_slot = ext_idx[ElemIdxWidth-1:LaneIdWidth];

  always_comb begin
    acc_d = red_first_i ? '0 : acc_q;
    if (red_op_i == VCPOP_M) begin
      for (int l = 0; l < NrLanes; l++) begin
        if (red_active_i[l] && lane_vs2_i[l][0]) begin
          acc_d = acc_d + elem_t'(1);
        end
      end
    end else if (red_slot_i == ext_slot && red_active_i[ext_lane]) begin
      // Index at or above vl is never active and leaves zero
      acc_d = lane_vs2_i[ext_lane];
    end
  end

  always_ff @(posedge clk_i) begin
    if (red_valid_i) begin
      acc_q <= acc_d;
    end
    if (red_valid_i && red_last_i) begin
      resp_data_o <= acc_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else if (red_valid_i && red_last_i) begin
      resp_valid_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_o <= 1'b0;
    end
  end

  assign red_ready_o = ~resp_valid_o;

endmodule : vec_mask_unit

// ==== source/vec_lane.sv ====
/*
  One lane: a slice of every vector register plus an integer ALU.
  Register contents are undefined after reset. Writeback uses the
  operands read in the previous cycle, so the sequencer must keep
  dependent reads away from pending writes.
*/
`timescale 1ns/1ps

module vec_lane import vec_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [LaneIdWidth-1:0] lane_id_i,
  // Operand read
  input  logic                   rd_valid_i,
  input  slot_t                  rd_slot_i,
  input  vreg_t                  rd_vs1_i,
  input  vreg_t                  rd_vs2_i,
  // Execute and writeback
  input  logic                   wb_valid_i,
  input  slot_t                  wb_slot_i,
  input  vreg_t                  wb_vd_i,
  input  vec_op_e                wb_op_i,
  input  elem_t                  wb_scalar_i,
  input  logic [NrLanes-1:0]     wb_active_i,
  // Raw vs2 element for the mask unit
  output elem_t                  lane_vs2_o
);

  // Register file slice, one row per vector register
  elem_t vrf [NrVRegs][SlotsPerLane];

  logic  opnd_valid_q;
  elem_t vs1_q;
  elem_t vs2_q;
  elem_t result;
  logic  wen;

  //////////////////////////////////////////////////////////////////////
  // Read stage
  //////////////////////////////////////////////////////////////////////

  assign lane_vs2_o = vrf[rd_vs2_i][rd_slot_i];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      opnd_valid_q <= 1'b0;
    end else begin
      opnd_valid_q <= rd_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      vs1_q <= vrf[rd_vs1_i][rd_slot_i];
      vs2_q <= lane_vs2_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Execute and writeback stage
  //////////////////////////////////////////////////////////////////////

  // Wrap-around integer arithmetic
  always_comb begin
    case (wb_op_i)
      VADD_VV: result = vs2_q + vs1_q;
      VSUB_VV: result = vs2_q - vs1_q;
      VAND_VV: result = vs2_q & vs1_q;
      VOR_VV:  result = vs2_q | vs1_q;
      VXOR_VV: result = vs2_q ^ vs1_q;
      VADD_VX: result = vs2_q + wb_scalar_i;
      VMV_VX:  result = wb_scalar_i;
      default: result = vs2_q;
    endcase
  end

  // Tail elements keep their old value
  assign wen = wb_valid_i & opnd_valid_q & wb_active_i[lane_id_i];

  always_ff @(posedge clk_i) begin
    if (wen) begin
      vrf[wb_vd_i][wb_slot_i] <= result;
    end
  end

endmodule : vec_lane

// ==== source/vec_sequencer.sv ====
/*
  Steps each instruction through the lanes one slot per cycle.
  A new instruction may be taken during the last read slot of the
  previous one. Operands are not forwarded, so any register overlap
  with an in-flight destination stalls until that writeback is done.
*/
`timescale 1ns/1ps

module vec_sequencer import vec_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // From the dispatcher
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  input  vec_op_e            issue_op_i,
  input  vreg_t              issue_vd_i,
  input  vreg_t              issue_vs1_i,
  input  vreg_t              issue_vs2_i,
  input  elem_t              issue_scalar_i,
  input  vl_t                issue_vl_i,
  // Operand read, broadcast to the lanes
  output logic               rd_valid_o,
  output slot_t              rd_slot_o,
  output vreg_t              rd_vs1_o,
  output vreg_t              rd_vs2_o,
  // Writeback, one cycle after the read
  output logic               wb_valid_o,
  output slot_t              wb_slot_o,
  output vreg_t              wb_vd_o,
  output vec_op_e            wb_op_o,
  output elem_t              wb_scalar_o,
  output logic [NrLanes-1:0] wb_active_o,
  // Reductions towards the mask unit
  output logic               red_valid_o,
  output logic               red_first_o,
  output logic               red_last_o,
  output vec_op_e            red_op_o,
  output slot_t              red_slot_o,
  output logic [NrLanes-1:0] red_active_o,
  output elem_t              red_index_o,
  input  logic               red_ready_i,
  output logic               busy_o
);

  // Read stage
  logic               act_q;
  slot_t              slot_q;
  vec_op_e            op_q;
  vreg_t              vd_q;
  vreg_t              vs1_q;
  vreg_t              vs2_q;
  elem_t              scalar_q;
  vl_t                vl_q;
  vl_t                vl_m1;
  slot_t              last_slot;
  logic               last;
  logic [NrLanes-1:0] rd_active;

  // Destinations still to be written
  logic [NrInFlight-1:0] trk_valid;
  vreg_t                 trk_vd [NrInFlight];
  logic                  hazard;
  logic                  red_block;
  logic                  issue_fire;

  //////////////////////////////////////////////////////////////////////
  // Slot stepping and active lanes
  //////////////////////////////////////////////////////////////////////

  // vl of 0 still takes one read cycle with all lanes off
  assign vl_m1     = vl_q - vl_t'(1);
  assign last_slot = (vl_q == '0) ? '0 : slot_t'(vl_m1 >> LaneIdWidth);
  assign last      = act_q & (slot_q == last_slot);

  always_comb begin
    logic [ElemIdxWidth-1:0] elem_idx;
    for (int l = 0; l < NrLanes; l++) begin
      elem_idx     = {slot_q, LaneIdWidth'(l)};
      rd_active[l] = (vl_t'(elem_idx) < vl_q);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Hazards and issue
  //////////////////////////////////////////////////////////////////////

  assign trk_valid[0] = act_q & ~is_reduction(op_q);
  assign trk_vd[0]    = vd_q;
  assign trk_valid[1] = wb_valid_o;
  assign trk_vd[1]    = wb_vd_o;

  always_comb begin
    hazard = 1'b0;
    for (int i = 0; i < NrInFlight; i++) begin
      if (trk_valid[i] && (trk_vd[i] == issue_vs1_i || trk_vd[i] == issue_vs2_i ||
                           trk_vd[i] == issue_vd_i)) begin
        hazard = 1'b1;
      end
    end
  end

  // Mask unit busy, or another reduction still reading
  assign red_block = is_reduction(issue_op_i) &
                     (~red_ready_i | (act_q & is_reduction(op_q)));

  assign issue_ready_o = (~act_q | last) & ~hazard & ~red_block;
  assign issue_fire    = issue_valid_i & issue_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      act_q  <= 1'b0;
      slot_q <= '0;
    end else if (issue_fire) begin
      act_q  <= 1'b1;
      slot_q <= '0;
    end else if (act_q) begin
      act_q  <= ~last;
      slot_q <= slot_q + slot_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      op_q     <= issue_op_i;
      vd_q     <= issue_vd_i;
      vs1_q    <= issue_vs1_i;
      vs2_q    <= issue_vs2_i;
      scalar_q <= issue_scalar_i;
      vl_q     <= issue_vl_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Writeback stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= act_q & ~is_reduction(op_q);
    end
  end

  always_ff @(posedge clk_i) begin
    wb_slot_o   <= slot_q;
    wb_vd_o     <= vd_q;
    wb_op_o     <= op_q;
    wb_scalar_o <= scalar_q;
    wb_active_o <= rd_active;
  end

  assign rd_valid_o = act_q;
  assign rd_slot_o  = slot_q;
  assign rd_vs1_o   = vs1_q;
  assign rd_vs2_o   = vs2_q;

  assign red_valid_o  = act_q & is_reduction(op_q);
  assign red_first_o  = (slot_q == '0);
  assign red_last_o   = last;
  assign red_op_o     = op_q;
  assign red_slot_o   = slot_q;
  assign red_active_o = rd_active;
  assign red_index_o  = scalar_q;

  assign busy_o = act_q | wb_valid_o;

endmodule : vec_sequencer

// ==== source/vec_dispatcher.sv ====
/*
  Front end holding a single request.
  vl above VlMax is clamped on entry. A scalar operation is not
  offered downstream while an earlier scalar response is still pending.
*/
`timescale 1ns/1ps

module vec_dispatcher import vec_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Request port
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  vec_op_e req_op_i,
  input  vreg_t   req_vd_i,
  input  vreg_t   req_vs1_i,
  input  vreg_t   req_vs2_i,
  input  elem_t   req_scalar_i,
  input  vl_t     req_vl_i,
  // Towards the sequencer
  output logic    issue_valid_o,
  input  logic    issue_ready_i,
  output vec_op_e issue_op_o,
  output vreg_t   issue_vd_o,
  output vreg_t   issue_vs1_o,
  output vreg_t   issue_vs2_o,
  output elem_t   issue_scalar_o,
  output vl_t     issue_vl_o,
  // Scalar response still waiting at the output
  input  logic    resp_pending_i
);

  logic held_q;
  logic req_fire;
  logic issue_fire;

  assign req_ready_o = ~held_q;
  assign req_fire    = req_valid_i & req_ready_o;

  // Only one scalar result may be outstanding at the output
  assign issue_valid_o = held_q & ~(is_reduction(issue_op_o) & resp_pending_i);
  assign issue_fire    = issue_valid_o & issue_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q <= 1'b0;
    end else if (req_fire) begin
      held_q <= 1'b1;
    end else if (issue_fire) begin
      held_q <= 1'b0;
    end
  end

  // Request fields
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      issue_op_o     <= req_op_i;
      issue_vd_o     <= req_vd_i;
      issue_vs1_o    <= req_vs1_i;
      issue_vs2_o    <= req_vs2_i;
      issue_scalar_o <= req_scalar_i;
      issue_vl_o     <= (req_vl_i > vl_t'(VlMax)) ? vl_t'(VlMax) : req_vl_i;
    end
  end

endmodule : vec_dispatcher

// ==== source/vec_pkg.sv ====
/*
  Shared sizes, types and operation codes of the vector coprocessor.
  VlMax must stay a power of two: element indices are split into
  lane and slot fields by bit slicing.
*/
package vec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned SlotsPerLane = 4;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VlMax        = NrLanes * SlotsPerLane;
  // Read stage plus writeback stage
  localparam int unsigned NrInFlight   = 2;

  // Derived field widths
  localparam int unsigned LaneIdWidth  = $clog2(NrLanes);
  localparam int unsigned SlotWidth    = $clog2(SlotsPerLane);
  localparam int unsigned ElemIdxWidth = $clog2(VlMax);
  localparam int unsigned VRegWidth    = $clog2(NrVRegs);
  localparam int unsigned VlWidth      = $clog2(VlMax + 1);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [VRegWidth-1:0] vreg_t;
  typedef logic [VlWidth-1:0]   vl_t;
  typedef logic [SlotWidth-1:0] slot_t;

  typedef enum logic [3:0] {
    VADD_VV = 4'd0,
    VSUB_VV = 4'd1,
    VAND_VV = 4'd2,
    VOR_VV  = 4'd3,
    VXOR_VV = 4'd4,
    VADD_VX = 4'd5,
    VMV_VX  = 4'd6,
    VCPOP_M = 4'd7,
    VEXT_XV = 4'd8
  } vec_op_e;

  // Operations that return a scalar instead of writing vd
  function automatic logic is_reduction(vec_op_e op);
    return (op == VCPOP_M) || (op == VEXT_XV);
  endfunction

endpackage : vec_pkg
